//--- design/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Widths and sizes
`define DATA_W      32
`define REG_ADDR_W  5
`define NUM_LANES   3
`define MEM_WORDS   64
`define MEM_ADDR_W  6

// Major opcodes
`define OP_REG      7'b0110011
`define OP_IMM      7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011

// ALU funct3 / funct7 codes
`define F3_ADD_SUB  3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F7_SUB      7'b0100000

`endif

//--- design/core_pkg.sv
`include "core_consts.svh"

package core_pkg;

    // ==============================
    // Basic scalar types
    // ==============================

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]             opcode_t;
    typedef logic [2:0]             funct3_t;

    // Enough bits to name any lane
    typedef logic [1:0]             lane_id_t;

    // ==============================
    // Instruction views
    // ==============================

    // Register-register format
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        funct3_t    funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } r_fmt_t;

    // Immediate and load format
    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        funct3_t     funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_fmt_t;

    // Store format, immediate split around rs1/rs2
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        funct3_t    funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    // Opcode field sits in the same place in every view
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } inst_word_u;

endpackage

//--- design/mem_bus_if.sv
`timescale 1ns/1ps

`include "core_consts.svh"

interface mem_bus_if;
    import core_pkg::*;

    // Lane side
    logic                   req;
    logic                   we;
    logic [`MEM_ADDR_W-1:0] addr;
    word_t                  wdata;

    // Arbiter side
    logic                   gnt;
    logic                   rvalid;
    word_t                  rdata;

    modport lane (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

//--- design/exec_lane.sv
`timescale 1ns/1ps

`include "core_consts.svh"

module exec_lane (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_issue_valid,
    input  core_pkg::inst_word_u i_issue_inst,
    input  core_pkg::word_t    i_rs1_val,
    input  core_pkg::word_t    i_rs2_val,
    output logic               o_issue_ready,
    output logic               o_wb_valid,
    output logic               o_wb_we,
    output core_pkg::reg_addr_t o_wb_rd,
    output core_pkg::word_t    o_wb_data,
    mem_bus_if.lane            bus
);
    import core_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_WB} state_t;

    state_t                 state;
    logic                   accept;
    logic                   is_reg;
    logic                   is_load;
    logic                   is_store;
    logic                   is_mem;
    word_t                  imm_i;
    word_t                  imm_s;
    word_t                  op_b;
    word_t                  alu_res;
    word_t                  eff_addr;
    logic                   req_we;
    logic [`MEM_ADDR_W-1:0] req_addr;
    word_t                  req_wdata;

    // ==============================
    // Decode
    // ==============================

    assign is_reg   = (i_issue_inst.r.opcode == `OP_REG);
    assign is_load  = (i_issue_inst.r.opcode == `OP_LOAD);
    assign is_store = (i_issue_inst.r.opcode == `OP_STORE);
    assign is_mem   = is_load | is_store;

    assign imm_i = {{(`DATA_W-12){i_issue_inst.i.imm[11]}}, i_issue_inst.i.imm};
    assign imm_s = {{(`DATA_W-12){i_issue_inst.s.imm_hi[6]}},
                    i_issue_inst.s.imm_hi, i_issue_inst.s.imm_lo};

    assign op_b = is_reg ? i_rs2_val : imm_i;

    // SUB only exists in the register form
    always_comb begin
        case (i_issue_inst.r.funct3)
            `F3_ADD_SUB: begin
                if (is_reg && i_issue_inst.r.funct7 == `F7_SUB) begin
                    alu_res = i_rs1_val - op_b;
                end else begin
                    alu_res = i_rs1_val + op_b;
                end
            end
            `F3_SLT: alu_res = {{(`DATA_W-1){1'b0}}, $signed(i_rs1_val) < $signed(op_b)};
            `F3_XOR: alu_res = i_rs1_val ^ op_b;
            `F3_OR:  alu_res = i_rs1_val | op_b;
            `F3_AND: alu_res = i_rs1_val & op_b;
            default: alu_res = '0;
        endcase
    end

    // Byte address, then word index
    assign eff_addr = i_rs1_val + (is_store ? imm_s : imm_i);

    // ==============================
    // Sequencing
    // ==============================

    assign o_issue_ready = (state == S_IDLE) || (state == S_WB);
    assign accept        = i_issue_valid && o_issue_ready;
    assign o_wb_valid    = (state == S_WB);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state  <= S_IDLE;
            req_we <= 1'b0;
        end else if (accept) begin
            state  <= is_mem ? S_REQ : S_WB;
            req_we <= is_store;
        end else begin
            case (state)
                S_REQ: begin
                    if (bus.gnt) begin
                        state <= req_we ? S_WB : S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (bus.rvalid) begin
                        state <= S_WB;
                    end
                end
                S_WB:    state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Result and request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            o_wb_we   <= !is_store;
            o_wb_rd   <= is_store ? '0 : i_issue_inst.i.rd;
            o_wb_data <= is_mem ? '0 : alu_res;
            req_addr  <= eff_addr[`MEM_ADDR_W+1:2];
            req_wdata <= i_rs2_val;
        end else if (state == S_WAIT && bus.rvalid) begin
            o_wb_data <= bus.rdata;
        end
    end

    assign bus.req   = (state == S_REQ);
    assign bus.we    = req_we;
    assign bus.addr  = req_addr;
    assign bus.wdata = req_wdata;

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ps

`include "core_consts.svh"

module mem_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    mem_bus_if.arbiter             lanes [`NUM_LANES],
    output logic                   o_ram_en,
    output logic                   o_ram_we,
    output logic [`MEM_ADDR_W-1:0] o_ram_addr,
    output core_pkg::word_t        o_ram_wdata,
    input  core_pkg::word_t        i_ram_rdata
);
    import core_pkg::*;

    logic [`NUM_LANES-1:0]  req_vec;
    logic [`NUM_LANES-1:0]  we_vec;
    logic [`MEM_ADDR_W-1:0] addr_vec [`NUM_LANES];
    word_t                  wdata_vec [`NUM_LANES];

    lane_id_t last_gnt;
    lane_id_t win;
    logic     grant_any;
    logic     rd_pend;
    lane_id_t rd_lane;

    // Flatten the interface array so it can be indexed by a variable
    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        assign req_vec[g]   = lanes[g].req;
        assign we_vec[g]    = lanes[g].we;
        assign addr_vec[g]  = lanes[g].addr;
        assign wdata_vec[g] = lanes[g].wdata;

        assign lanes[g].gnt    = grant_any && (win == lane_id_t'(g));
        assign lanes[g].rvalid = rd_pend && (rd_lane == lane_id_t'(g));
        assign lanes[g].rdata  = i_ram_rdata;
    end

    // ==============================
    // Round-robin pick
    // ==============================

    // Walk backwards so the lane right after last_gnt wins
    always_comb begin
        int idx;
        win       = last_gnt;
        grant_any = 1'b0;
        for (int i = `NUM_LANES; i >= 1; i--) begin
            idx = (int'(last_gnt) + i) % `NUM_LANES;
            if (req_vec[idx]) begin
                win       = lane_id_t'(idx);
                grant_any = 1'b1;
            end
        end
    end

    assign o_ram_en    = grant_any;
    assign o_ram_we    = we_vec[win];
    assign o_ram_addr  = addr_vec[win];
    assign o_ram_wdata = wdata_vec[win];

    // Pointer and read return tracking
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            last_gnt <= lane_id_t'(`NUM_LANES - 1);
            rd_pend  <= 1'b0;
            rd_lane  <= '0;
        end else begin
            rd_pend <= grant_any && !we_vec[win];
            if (grant_any) begin
                last_gnt <= win;
                rd_lane  <= win;
            end
        end
    end

endmodule

//--- design/data_ram.sv
`timescale 1ns/1ps

`include "core_consts.svh"

module data_ram (
    input  logic                   clk,
    input  logic                   i_en,
    input  logic                   i_we,
    input  logic [`MEM_ADDR_W-1:0] i_addr,
    input  core_pkg::word_t        i_wdata,
    output core_pkg::word_t        o_rdata
);
    import core_pkg::*;

    word_t mem [`MEM_WORDS];

    // Write on enable+we, otherwise a registered read
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

//--- design/perf_counters.sv
`timescale 1ns/1ps

`include "core_consts.svh"

module perf_counters (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`NUM_LANES-1:0] i_retire,
    input  logic [`NUM_LANES-1:0] i_stall,
    output core_pkg::word_t       o_cycles,
    output core_pkg::word_t       o_retired,
    output core_pkg::word_t       o_mem_stalls
);
    import core_pkg::*;

    lane_id_t retire_cnt;
    lane_id_t stall_cnt;

    // Per-cycle population counts
    always_comb begin
        retire_cnt = '0;
        stall_cnt  = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            retire_cnt = retire_cnt + lane_id_t'(i_retire[i]);
            stall_cnt  = stall_cnt + lane_id_t'(i_stall[i]);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            o_cycles     <= '0;
            o_retired    <= '0;
            o_mem_stalls <= '0;
        end else begin
            o_cycles     <= o_cycles + 1'b1;
            o_retired    <= o_retired + word_t'(retire_cnt);
            o_mem_stalls <= o_mem_stalls + word_t'(stall_cnt);
        end
    end

endmodule

//--- design/lane_cluster_top.sv
`timescale 1ns/1ps

`include "core_consts.svh"

module lane_cluster_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [`NUM_LANES-1:0]                  i_issue_valid,
    input  core_pkg::inst_word_u [`NUM_LANES-1:0]  i_issue_inst,
    input  core_pkg::word_t [`NUM_LANES-1:0]       i_rs1_val,
    input  core_pkg::word_t [`NUM_LANES-1:0]       i_rs2_val,
    output logic [`NUM_LANES-1:0]                  o_issue_ready,
    output logic [`NUM_LANES-1:0]                  o_wb_valid,
    output logic [`NUM_LANES-1:0]                  o_wb_we,
    output core_pkg::reg_addr_t [`NUM_LANES-1:0]   o_wb_rd,
    output core_pkg::word_t [`NUM_LANES-1:0]       o_wb_data,
    output core_pkg::word_t                        o_perf_cycles,
    output core_pkg::word_t                        o_perf_retired,
    output core_pkg::word_t                        o_perf_mem_stalls
);

    logic [`NUM_LANES-1:0]  lane_retire;
    logic [`NUM_LANES-1:0]  lane_stall;

    logic                   ram_en;
    logic                   ram_we;
    logic [`MEM_ADDR_W-1:0] ram_addr;
    logic [`DATA_W-1:0]     ram_wdata;
    logic [`DATA_W-1:0]     ram_rdata;

    mem_bus_if bus_if [`NUM_LANES] ();

    // ==============================
    // Execution lanes
    // ==============================

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        exec_lane exec_lane_inst (
            .clk           (clk),
            .reset         (reset),
            .i_issue_valid (i_issue_valid[g]),
            .i_issue_inst  (i_issue_inst[g]),
            .i_rs1_val     (i_rs1_val[g]),
            .i_rs2_val     (i_rs2_val[g]),
            .o_issue_ready (o_issue_ready[g]),
            .o_wb_valid    (o_wb_valid[g]),
            .o_wb_we       (o_wb_we[g]),
            .o_wb_rd       (o_wb_rd[g]),
            .o_wb_data     (o_wb_data[g]),
            .bus           (bus_if[g].lane)
        );

        // Denied request this cycle
        assign lane_stall[g] = bus_if[g].req && !bus_if[g].gnt;
    end

    assign lane_retire = o_wb_valid;

    // ==============================
    // Shared memory path
    // ==============================

    mem_arbiter mem_arbiter_inst (
        .clk         (clk),
        .reset       (reset),
        .lanes       (bus_if),
        .o_ram_en    (ram_en),
        .o_ram_we    (ram_we),
        .o_ram_addr  (ram_addr),
        .o_ram_wdata (ram_wdata),
        .i_ram_rdata (ram_rdata)
    );

    data_ram data_ram_inst (
        .clk     (clk),
        .i_en    (ram_en),
        .i_we    (ram_we),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

    perf_counters perf_counters_inst (
        .clk          (clk),
        .reset        (reset),
        .i_retire     (lane_retire),
        .i_stall      (lane_stall),
        .o_cycles     (o_perf_cycles),
        .o_retired    (o_perf_retired),
        .o_mem_stalls (o_perf_mem_stalls)
    );

endmodule

//--- dv/lane_cluster_assertions.sv
`timescale 1ns/1ps

`include "core_consts.svh"

module lane_cluster_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic [`NUM_LANES-1:0] req,
    input logic [`NUM_LANES-1:0] we,
    input logic [`NUM_LANES-1:0] gnt,
    input logic [`NUM_LANES-1:0] rvalid,
    input logic [`NUM_LANES-1:0] issue_valid,
    input logic [`NUM_LANES-1:0] issue_ready,
    input logic [`NUM_LANES-1:0] wb_valid
);

    // Lanes holding an accepted operation
    logic [`NUM_LANES-1:0] pending;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~wb_valid) | (issue_valid & issue_ready);
        end
    end

    // ==============================
    // Arbiter and bus handshakes
    // ==============================

    a_single_gnt: assert property (@(posedge clk) disable iff (!reset)
        $onehot0(gnt) && ((gnt & ~req) == '0))
        else $error("gnt to more than one lane or to a lane without req");

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        a_req_held: assert property (@(posedge clk) disable iff (!reset)
            req[g] && !gnt[g] |=> req[g])
            else $error("lane %0d dropped req before gnt", g);

        a_rvalid_after_read: assert property (@(posedge clk) disable iff (!reset)
            gnt[g] && !we[g] |=> rvalid[g])
            else $error("lane %0d read gnt not followed by rvalid", g);

        a_rvalid_source: assert property (@(posedge clk) disable iff (!reset)
            rvalid[g] |-> $past(gnt[g] && !we[g]))
            else $error("lane %0d rvalid without a read gnt one cycle earlier", g);

        a_busy_not_ready: assert property (@(posedge clk) disable iff (!reset)
            pending[g] && !wb_valid[g] |-> !issue_ready[g])
            else $error("lane %0d ready while an operation is pending", g);
    end

endmodule

bind lane_cluster_top lane_cluster_assertions lane_cluster_assertions_inst (
    .clk         (clk),
    .reset       (reset),
    .req         ({bus_if[2].req, bus_if[1].req, bus_if[0].req}),
    .we          ({bus_if[2].we, bus_if[1].we, bus_if[0].we}),
    .gnt         ({bus_if[2].gnt, bus_if[1].gnt, bus_if[0].gnt}),
    .rvalid      ({bus_if[2].rvalid, bus_if[1].rvalid, bus_if[0].rvalid}),
    .issue_valid (i_issue_valid),
    .issue_ready (o_issue_ready),
    .wb_valid    (o_wb_valid)
);

//--- dv/lane_cluster_tb.sv
`timescale 1ns/1ps

`include "core_consts.svh"

module lane_cluster_tb;
    import core_pkg::*;

    localparam int CLK_PERIOD       = 100;
    localparam int RESET_CYCLES     = 5;
    localparam int CYCLES_PER_GROUP = 40;

    // One line of the input file
    typedef struct {
        int        group;
        int        lane;
        word_t     inst;
        word_t     rs1;
        word_t     rs2;
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } op_t;

    logic                       clk;
    logic                       reset;
    logic [`NUM_LANES-1:0]      issue_valid;
    word_t [`NUM_LANES-1:0]     issue_inst;
    word_t [`NUM_LANES-1:0]     rs1_val;
    word_t [`NUM_LANES-1:0]     rs2_val;
    logic [`NUM_LANES-1:0]      issue_ready;
    logic [`NUM_LANES-1:0]      wb_valid;
    logic [`NUM_LANES-1:0]      wb_we;
    reg_addr_t [`NUM_LANES-1:0] wb_rd;
    word_t [`NUM_LANES-1:0]     wb_data;
    word_t                      perf_cycles;
    word_t                      perf_retired;
    word_t                      perf_mem_stalls;

    op_t ops[$];
    int  num_groups  = 0;
    int  error_count = 0;
    int  cycle_count = 0;
    bit  loaded      = 1'b0;

    lane_cluster_top lane_cluster_top_inst (
        .clk               (clk),
        .reset             (reset),
        .i_issue_valid     (issue_valid),
        .i_issue_inst      (issue_inst),
        .i_rs1_val         (rs1_val),
        .i_rs2_val         (rs2_val),
        .o_issue_ready     (issue_ready),
        .o_wb_valid        (wb_valid),
        .o_wb_we           (wb_we),
        .o_wb_rd           (wb_rd),
        .o_wb_data         (wb_data),
        .o_perf_cycles     (perf_cycles),
        .o_perf_retired    (perf_retired),
        .o_perf_mem_stalls (perf_mem_stalls)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Reference count of cycles since reset release
    always @(posedge clk) begin
        if (reset) begin
            cycle_count <= cycle_count + 1;
        end
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic load_ops();
        int    fd;
        int    cnt;
        int    grp;
        int    ln;
        int    we_i;
        int    rd_i;
        word_t inst;
        word_t rs1;
        word_t rs2;
        word_t data;
        string line;
        fd = $fopen("dv/lane_cluster_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/lane_cluster_input.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
                cnt = $sscanf(line, "%d %d %h %h %h %d %d %h",
                              grp, ln, inst, rs1, rs2, we_i, rd_i, data);
                // Comment and blank lines scan nothing
                if (cnt == 8 && ln >= 0 && ln < `NUM_LANES) begin
                    ops.push_back('{grp, ln, inst, rs1, rs2, we_i[0], rd_i[4:0], data});
                    if (grp + 1 > num_groups) begin
                        num_groups = grp + 1;
                    end
                end else if (cnt > 0) begin
                    error_count++;
                    $display("Malformed input line skipped: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    function automatic bit is_mem_op(input word_t inst);
        return inst[6:0] == `OP_LOAD || inst[6:0] == `OP_STORE;
    endfunction

    // Denied lane-cycles for a group or -1 if a lane gets more than one op
    function automatic int expected_stalls(input int group);
        int per_lane[`NUM_LANES];
        int mem_ops;
        per_lane = '{default: 0};
        mem_ops = 0;
        foreach (ops[i]) begin
            if (ops[i].group == group) begin
                per_lane[ops[i].lane]++;
                if (is_mem_op(ops[i].inst)) begin
                    mem_ops++;
                end
            end
        end
        foreach (per_lane[l]) begin
            if (per_lane[l] > 1) begin
                return -1;
            end
        end
        return mem_ops * (mem_ops - 1) / 2;
    endfunction

    task automatic drive_op(input int lane, input op_t op);
        issue_valid[lane] = 1'b1;
        issue_inst[lane]  = op.inst;
        rs1_val[lane]     = op.rs1;
        rs2_val[lane]     = op.rs2;
    endtask

    task automatic check_result(input int lane, input op_t op, input int age);
        check_value($sformatf("o_wb_we[%0d]", lane), word_t'(op.we), word_t'(wb_we[lane]));
        check_value($sformatf("o_wb_rd[%0d]", lane), word_t'(op.rd), word_t'(wb_rd[lane]));
        check_value($sformatf("o_wb_data[%0d]", lane), op.data, wb_data[lane]);
        // ALU results come back one cycle after acceptance
        if (!is_mem_op(op.inst)) begin
            check_value($sformatf("ALU latency lane %0d", lane), 32'd1, word_t'(age));
        end
    endtask

    // Offers one lane's ops in order and samples at the falling edge
    task automatic run_lane(input int lane, input int group);
        int   idx_q[$];
        int   offered;
        int   checked;
        int   age;
        logic pending;
        logic accepted_now;
        foreach (ops[i]) begin
            if (ops[i].group == group && ops[i].lane == lane) begin
                idx_q.push_back(i);
            end
        end
        if (idx_q.size() == 0) begin
            return;
        end
        offered = 0;
        checked = 0;
        age     = 0;
        pending = 1'b0;
        drive_op(lane, ops[idx_q[0]]);
        while (checked < idx_q.size()) begin
            @(negedge clk);
            accepted_now = issue_valid[lane] && issue_ready[lane];
            if (pending) begin
                age++;
            end
            if (pending && !wb_valid[lane]) begin
                check_value($sformatf("o_issue_ready[%0d]", lane), 32'd0,
                            word_t'(issue_ready[lane]));
            end
            if (wb_valid[lane]) begin
                if (!pending) begin
                    error_count++;
                    $display("error at %0t ns: lane %0d completed with no operation outstanding",
                             $time, lane);
                end else begin
                    check_result(lane, ops[idx_q[checked]], age);
                    checked++;
                end
                pending = 1'b0;
            end
            if (accepted_now) begin
                pending = 1'b1;
                age     = 0;
                offered++;
            end
            @(posedge clk);
            #1;
            if (accepted_now) begin
                if (offered < idx_q.size()) begin
                    drive_op(lane, ops[idx_q[offered]]);
                end else begin
                    issue_valid[lane] = 1'b0;
                end
            end
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        word_t stall_base;
        int    budget;
        reset       = 1'b0;
        issue_valid = '0;
        issue_inst  = '0;
        rs1_val     = '0;
        rs2_val     = '0;
        load_ops();
        loaded = (ops.size() > 0);
        if (!loaded) begin
            $display("No operations could be read from the input file");
        end else begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_value("o_issue_ready", (1 << `NUM_LANES) - 1, word_t'(issue_ready));
            check_value("o_wb_valid", 32'd0, word_t'(wb_valid));
            check_value("o_perf_cycles", 32'd0, perf_cycles);
            check_value("o_perf_retired", 32'd0, perf_retired);
            check_value("o_perf_mem_stalls", 32'd0, perf_mem_stalls);
            repeat (RESET_CYCLES - 2) @(posedge clk);
            #1;
            reset = 1'b1;
            for (int g = 0; g < num_groups; g++) begin
                stall_base = perf_mem_stalls;
                budget     = expected_stalls(g);
                for (int l = 0; l < `NUM_LANES; l++) begin
                    fork
                        automatic int lane = l;
                        run_lane(lane, g);
                    join_none
                end
                wait fork;
                if (budget >= 0) begin
                    check_value($sformatf("o_perf_mem_stalls increase in group %0d", g),
                                word_t'(budget), perf_mem_stalls - stall_base);
                end
            end
            check_value("o_perf_retired", word_t'(ops.size()), perf_retired);
            check_value("o_perf_cycles", word_t'(cycle_count), perf_cycles);
        end
        $display("Run complete: %0d operations, %0d errors", ops.size(), error_count);
        if (loaded && error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized from the number of groups
    initial begin
        wait (loaded);
        #((RESET_CYCLES + CYCLES_PER_GROUP * num_groups) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles",
                 RESET_CYCLES + CYCLES_PER_GROUP * num_groups);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- dv/lane_cluster_input.txt
# group lane inst rs1 rs2 wb_we wb_rd wb_data
# group, lane, wb_we and wb_rd are decimal; inst, rs1, rs2 and wb_data are hex
0 0 002081B3 00000010 00000025 1 3 00000035
0 1 407302B3 00000005 00000009 1 5 FFFFFFFC
0 2 00A4C433 F0F0F0F0 0FF00FF0 1 8 FF00FF00
1 0 00D675B3 12345678 0000FFFF 1 11 00005678
1 1 0107E733 00FF0000 000000FF 1 14 00FF00FF
1 2 013928B3 FFFFFFFF 00000001 1 17 00000001
2 0 FFC10093 00000100 00000000 1 1 000000FC
2 1 7FF2C213 0000F00F 00000000 1 4 0000F7F0
2 2 FF03E313 00000005 00000000 1 6 FFFFFFF5
3 0 0020A023 00000040 DEADBEEF 0 0 00000000
3 1 0041A423 00000020 CAFEF00D 0 0 00000000
3 2 FE62AE23 00000084 13579BDF 0 0 00000000
4 0 00042383 00000080 00000000 1 7 13579BDF
4 1 00452483 0000003C 00000000 1 9 DEADBEEF
4 2 FF862583 00000030 00000000 1 11 CAFEF00D
5 0 0F077693 12345678 00000000 1 13 00000070
5 1 00F82623 00000000 0BADF00D 0 0 00000000
5 1 016A8A33 7FFFFFFF 00000001 1 20 80000000
5 2 000C2B83 00000028 00000000 1 23 CAFEF00D
5 2 41BD0CB3 00000000 00000001 1 25 FFFFFFFF

//--- files.f
+incdir+design
design/core_pkg.sv
design/mem_bus_if.sv
design/exec_lane.sv
design/mem_arbiter.sv
design/data_ram.sv
design/perf_counters.sv
design/lane_cluster_top.sv
dv/lane_cluster_assertions.sv
dv/lane_cluster_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := lane_cluster_tb
FILELIST   := files.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(BUILD_DIR)
